// File: Makefile
# Verilator build for the residual adder testbench
#
# make compile   build the simulation executable
# make run       run it and decide pass or fail from the log
# make clean     remove build products and the log

VERILATOR ?= verilator
TOP       ?= tb_residual_add
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= sim passed

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) \
		--top-module $(TOP) \
		--Mdir $(BUILD_DIR) \
		-f $(FILELIST)

run: compile
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sources.f
src/fixed_pkg.sv
src/pipe_reg_slice.sv
src/fixed_round_sat.sv
src/fixed_adder.sv
src/residual_add_top.sv
test/tb_residual_add.sv

// File: src/fixed_adder.sv
module fixed_adder
    import fixed_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  in0_vec_t data_in_0,
    input  logic     data_in_0_valid,
    output logic     data_in_0_ready,

    input  in1_vec_t data_in_1,
    input  logic     data_in_1_valid,
    output logic     data_in_1_ready,

    output out_vec_t data_out,
    output logic     data_out_valid,
    input  logic     data_out_ready
);

    logic     joined_valid;
    logic     joined_ready;
    sum_vec_t lane_sum;
    out_vec_t cast_out;

    // Join, a beat moves only when both streams have one
    assign joined_valid = data_in_0_valid && data_in_1_valid;
    assign data_in_0_ready = joined_ready && data_in_1_valid;
    assign data_in_1_ready = joined_ready && data_in_0_valid;

    // Lane sums at full width, no overflow possible here
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_sum[i] = sum_lane_t'($signed(data_in_0[i]))
                        + sum_lane_t'($signed(data_in_1[i]));
        end
    end

    // Round and saturate to the output format
    fixed_round_sat cast_i (
        .data_in (lane_sum),
        .data_out(cast_out)
    );

    // Output register
    pipe_reg_slice #(
        .payload_t(out_vec_t)
    ) out_slice_i (
        .clk           (clk),
        .reset         (reset),
        .data_in       (cast_out),
        .data_in_valid (joined_valid),
        .data_in_ready (joined_ready),
        .data_out      (data_out),
        .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready)
    );

endmodule

// File: src/fixed_pkg.sv
package fixed_pkg;

    // Lanes carried in every beat
    localparam int num_lanes = 4;

    // Stream 0, the layer output
    localparam int in0_width = 16;
    localparam int in0_frac = 3;

    // Stream 1, the skip connection
    localparam int in1_width = 12;
    localparam int in1_frac = 3;

    // Full-width sum, one guard bit over the wider input
    localparam int sum_width = (in0_width > in1_width ? in0_width : in1_width) + 1;
    localparam int sum_frac = (in0_frac > in1_frac ? in0_frac : in1_frac);

    // Output format
    localparam int out_width = 12;
    localparam int out_frac = 2;

    // Cast constants
    localparam int drop_bits = sum_frac - out_frac;
    localparam int round_width = sum_width + 1;
    localparam int round_half = 1 << (drop_bits - 1);
    localparam int out_max = 2 ** (out_width - 1) - 1;
    localparam int out_min = -(2 ** (out_width - 1));

    // Single lane types
    typedef logic signed [in0_width-1:0] in0_lane_t;
    typedef logic signed [in1_width-1:0] in1_lane_t;
    typedef logic signed [sum_width-1:0] sum_lane_t;
    typedef logic signed [out_width-1:0] out_lane_t;

    // Whole beats, lane 0 in the low bits
    typedef in0_lane_t [num_lanes-1:0] in0_vec_t;
    typedef in1_lane_t [num_lanes-1:0] in1_vec_t;
    typedef sum_lane_t [num_lanes-1:0] sum_vec_t;
    typedef out_lane_t [num_lanes-1:0] out_vec_t;

endpackage

// File: src/fixed_round_sat.sv
module fixed_round_sat
    import fixed_pkg::*;
(
    input  sum_vec_t data_in,
    output out_vec_t data_out
);

    // One spare bit so adding the half LSB cannot wrap
    typedef logic signed [round_width-1:0] round_t;

    round_t widened [num_lanes];
    round_t rounded [num_lanes];
    round_t shifted [num_lanes];

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane

        // Sign extend into the rounding width
        assign widened[i] = round_t'($signed(data_in[i]));

        // Half an output LSB, ties go toward plus infinity
        assign rounded[i] = widened[i] + round_t'(round_half);

        // Drop the extra fractional bits
        assign shifted[i] = rounded[i] >>> drop_bits;

        // Clamp to the signed output range
        always_comb begin
            if (shifted[i] > round_t'(out_max)) begin
                data_out[i] = out_lane_t'(out_max);
            end else if (shifted[i] < round_t'(out_min)) begin
                data_out[i] = out_lane_t'(out_min);
            end else begin
                // In range, the low bits are already the answer
                data_out[i] = out_lane_t'(shifted[i]);
            end
        end

    end

endmodule

// File: src/pipe_reg_slice.sv
module pipe_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    input  payload_t data_in,
    input  logic     data_in_valid,
    output logic     data_in_ready,

    output payload_t data_out,
    output logic     data_out_valid,
    input  logic     data_out_ready
);

    logic load;

    // Room for a new beat when empty or when the held beat leaves now
    assign data_in_ready = !data_out_valid || data_out_ready;
    assign load = data_in_valid && data_in_ready;

    // Valid flag of the held beat
    always_ff @(posedge clk) begin
        if (reset) begin
            data_out_valid <= 1'b0;
        end else if (data_in_ready) begin
            data_out_valid <= data_in_valid;
        end
    end

    // Payload only moves on an accepted beat
    always_ff @(posedge clk) begin
        if (load) begin
            data_out <= data_in;
        end
    end

endmodule

// File: src/residual_add_top.sv
module residual_add_top
    import fixed_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  in0_vec_t data_in_0,
    input  logic     data_in_0_valid,
    output logic     data_in_0_ready,

    input  in1_vec_t data_in_1,
    input  logic     data_in_1_valid,
    output logic     data_in_1_ready,

    output out_vec_t data_out,
    output logic     data_out_valid,
    input  logic     data_out_ready
);

    // Buffered stream 0
    in0_vec_t buf_data_0;
    logic     buf_valid_0;
    logic     buf_ready_0;

    // Buffered stream 1
    in1_vec_t buf_data_1;
    logic     buf_valid_1;
    logic     buf_ready_1;

    // Layer output slice
    pipe_reg_slice #(
        .payload_t(in0_vec_t)
    ) in0_slice_i (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in_0),
        .data_in_valid (data_in_0_valid),
        .data_in_ready (data_in_0_ready),
        .data_out      (buf_data_0),
        .data_out_valid(buf_valid_0),
        .data_out_ready(buf_ready_0)
    );

    // Skip connection slice
    pipe_reg_slice #(
        .payload_t(in1_vec_t)
    ) in1_slice_i (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in_1),
        .data_in_valid (data_in_1_valid),
        .data_in_ready (data_in_1_ready),
        .data_out      (buf_data_1),
        .data_out_valid(buf_valid_1),
        .data_out_ready(buf_ready_1)
    );

    // Join, add, cast and register
    fixed_adder adder_i (
        .clk            (clk),
        .reset          (reset),
        .data_in_0      (buf_data_0),
        .data_in_0_valid(buf_valid_0),
        .data_in_0_ready(buf_ready_0),
        .data_in_1      (buf_data_1),
        .data_in_1_valid(buf_valid_1),
        .data_in_1_ready(buf_ready_1),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

// File: test/tb_residual_add.sv
module tb_residual_add
    import fixed_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_beats = 500;
    localparam int reset_cycles = 8;
    localparam int clk_period = 100;
    localparam int drive_delay = 5;
    // Worst joint rate about one beat in four, then doubled
    localparam int timeout_cycles = num_beats * 4 * 2;

    logic     clk;
    logic     reset;
    in0_vec_t data_in_0;
    logic     data_in_0_valid;
    logic     data_in_0_ready;
    in1_vec_t data_in_1;
    logic     data_in_1_valid;
    logic     data_in_1_ready;
    out_vec_t data_out;
    logic     data_out_valid;
    logic     data_out_ready;

    // Scoreboard state
    in0_vec_t in0_q[$];
    in1_vec_t in1_q[$];
    out_vec_t exp_q[$];
    int       cycle_count = 0;
    int       sent_0 = 0;
    int       sent_1 = 0;
    int       accepted_0 = 0;
    int       accepted_1 = 0;
    int       out_count = 0;
    int       sat_hi = 0;
    int       sat_lo = 0;
    logic     took_0 = 1'b0;
    logic     took_1 = 1'b0;
    logic     held_valid = 1'b0;
    out_vec_t held_data = '0;
    logic     full_0;
    logic     full_1;
    logic     room;

    residual_add_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .data_in_0      (data_in_0),
        .data_in_0_valid(data_in_0_valid),
        .data_in_0_ready(data_in_0_ready),
        .data_in_1      (data_in_1),
        .data_in_1_valid(data_in_1_valid),
        .data_in_1_ready(data_in_1_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run aborted on first error");
    endtask

    task automatic check_vec(string name, out_vec_t expected, out_vec_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %h actual %h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b actual %b",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (actual != expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %0d actual %0d",
                                        $time, name, expected, actual));
        end
    endtask

    // Reference for one output beat, add then round half up then clamp
    function automatic out_vec_t expected_sum(in0_vec_t a, in1_vec_t b);
        out_vec_t res;
        int       total;
        int       shift;
        int       hi;
        int       lo;
        shift = in0_frac - out_frac;
        hi = (1 << (out_width - 1)) - 1;
        lo = -(1 << (out_width - 1));
        for (int i = 0; i < num_lanes; i++) begin
            total = int'(a[i]) + int'(b[i]);
            total = (total + (1 << (shift - 1))) >>> shift;
            if (total > hi) begin
                total = hi;
                sat_hi++;
            end else if (total < lo) begin
                total = lo;
                sat_lo++;
            end
            res[i] = out_lane_t'(total);
        end
        return res;
    endfunction

    // About one beat in eight uses extremes and tie values
    function automatic in0_vec_t random_in0_beat();
        in0_vec_t beat;
        logic     directed;
        directed = ($urandom_range(7) == 0);
        for (int i = 0; i < num_lanes; i++) begin
            if (directed) begin
                case ($urandom_range(3))
                    0: beat[i] = in0_lane_t'(2 ** (in0_width - 1) - 1);
                    1: beat[i] = in0_lane_t'(-(2 ** (in0_width - 1)));
                    2: beat[i] = in0_lane_t'(1);
                    default: beat[i] = in0_lane_t'(-1);
                endcase
            end else begin
                // Moderate range, most sums stay inside the output format
                beat[i] = in0_lane_t'(int'($urandom_range(4095)) - 2048);
            end
        end
        return beat;
    endfunction

    function automatic in1_vec_t random_in1_beat();
        in1_vec_t beat;
        logic     directed;
        directed = ($urandom_range(7) == 0);
        for (int i = 0; i < num_lanes; i++) begin
            if (directed) begin
                case ($urandom_range(3))
                    0: beat[i] = in1_lane_t'(2 ** (in1_width - 1) - 1);
                    1: beat[i] = in1_lane_t'(-(2 ** (in1_width - 1)));
                    2: beat[i] = in1_lane_t'(0);
                    default: beat[i] = in1_lane_t'(2);
                endcase
            end else begin
                beat[i] = in1_lane_t'($urandom_range(4095));
            end
        end
        return beat;
    endfunction

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure($sformatf("Timeout, the run did not finish within %0d cycles",
                                        timeout_cycles));
        end
    end

    // Monitor at the falling edge where every signal is settled
    always @(negedge clk) begin
        if (cycle_count >= 1 && cycle_count <= reset_cycles + 1) begin
            check_bit("data_out_valid", 1'b0, data_out_valid);
        end
        if (reset) begin
            took_0 = 1'b0;
            took_1 = 1'b0;
            held_valid = 1'b0;
        end else begin
            // An input slice is full when its stream has a beat inside besides the output one
            full_0 = (accepted_0 - out_count) > int'(data_out_valid);
            full_1 = (accepted_1 - out_count) > int'(data_out_valid);
            room = !data_out_valid || data_out_ready;
            check_bit("data_in_0_ready", !full_0 || (room && full_1), data_in_0_ready);
            check_bit("data_in_1_ready", !full_1 || (room && full_0), data_in_1_ready);
            took_0 = data_in_0_valid && data_in_0_ready;
            took_1 = data_in_1_valid && data_in_1_ready;
            if (took_0) begin
                in0_q.push_back(data_in_0);
                accepted_0++;
            end
            if (took_1) begin
                in1_q.push_back(data_in_1);
                accepted_1++;
            end
            // Pair beats strictly in arrival order
            while (in0_q.size() > 0 && in1_q.size() > 0) begin
                exp_q.push_back(expected_sum(in0_q.pop_front(), in1_q.pop_front()));
            end
            // Stalled beat must stay put
            if (held_valid) begin
                check_bit("data_out_valid", 1'b1, data_out_valid);
                check_vec("data_out", held_data, data_out);
            end
            if (data_out_valid && data_out_ready) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("An output beat appeared without a paired input beat");
                end
                check_vec("data_out", exp_q.pop_front(), data_out);
                out_count++;
            end
            held_valid = data_out_valid && !data_out_ready;
            held_data = data_out;
        end
    end

    initial begin
        void'($urandom(33));
        reset = 1'b1;
        data_in_0 = '0;
        data_in_0_valid = 1'b0;
        data_in_1 = '0;
        data_in_1_valid = 1'b0;
        data_out_ready = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        while (accepted_0 < num_beats || accepted_1 < num_beats) begin
            // New beat only once the previous one has gone
            if (!data_in_0_valid || took_0) begin
                if (sent_0 < num_beats && $urandom_range(99) < 60) begin
                    data_in_0 = random_in0_beat();
                    data_in_0_valid = 1'b1;
                    sent_0++;
                end else begin
                    data_in_0_valid = 1'b0;
                end
            end
            if (!data_in_1_valid || took_1) begin
                if (sent_1 < num_beats && $urandom_range(99) < 60) begin
                    data_in_1 = random_in1_beat();
                    data_in_1_valid = 1'b1;
                    sent_1++;
                end else begin
                    data_in_1_valid = 1'b0;
                end
            end
            data_out_ready = ($urandom_range(99) < 70);
            @(posedge clk);
            #drive_delay;
        end

        // Drain window, any late beat here has no pair
        data_in_0_valid = 1'b0;
        data_in_1_valid = 1'b0;
        data_out_ready = 1'b1;
        // Two cycles of latency, so every paired beat is out well within this
        repeat (8) @(posedge clk);

        check_count("output beats", num_beats, out_count);
        check_count("expected beats left over", 0, exp_q.size());
        if (sat_hi == 0 || sat_lo == 0) begin
            stop_with_failure("The stimulus did not reach both output saturation limits");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
